/* list.f */
+incdir+include
hdl/fetch_pkg.sv
hdl/pc_gen.sv
hdl/irq_select.sv
hdl/trap_csr.sv
hdl/fetch_axil.sv
hdl/fetch_top.sv
tests/fetch_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= fetch_tb
FILELIST ?= list.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -j 0
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: sim clean

# Build and run, the result comes from the simulator output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* include/fetch_tb_tasks.svh */
`ifndef FETCH_TB_TASKS_SVH
`define FETCH_TB_TASKS_SVH

task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
	checks++;
	assert (got === exp) else begin
		errors++;
		$display("ERROR %s: got %h expected %h", name, got, exp);
	end
endtask

// Polls on the falling edge clear of the monitor
task automatic wait_for_packets(input int count, output bit ok);
	int cycles;
	cycles = 0;
	while (got_q.size() < count && cycles < WAIT_LIMIT) begin
		@(negedge clk_i);
		cycles++;
	end
	ok = (got_q.size() >= count);
	checks++;
	assert (ok) else begin
		errors++;
		$display("Timed out waiting for %0d instructions, only %0d arrived", count, got_q.size());
	end
endtask

task automatic wait_for_pc(input logic [31:0] pc, output int idx);
	int cycles;
	idx = -1;
	cycles = 0;
	while (idx < 0 && cycles < WAIT_LIMIT) begin
		@(negedge clk_i);
		cycles++;
		foreach (got_q[i]) begin
			if (idx < 0 && got_q[i].pc == pc) idx = i;
		end
	end
	checks++;
	assert (idx >= 0) else begin
		errors++;
		$display("Timed out waiting for an instruction fetched from %h", pc);
	end
endtask

// Packets first..first+count-1 must run up from base by one word each
task automatic verify_stream(input logic [31:0] base, input int first, input int count);
	bit ok;
	logic [31:0] exp_pc;
	fetch_pkg::fetch_pkt_t pkt;
	wait_for_packets(first + count, ok);
	if (ok) begin
		for (int i = 0; i < count; i++) begin
			pkt = got_q[first + i];
			exp_pc = base + 32'(4 * i);
			compare_word("inst_o.pc", pkt.pc, exp_pc);
			compare_word("inst_o.instr", pkt.instr, instr_for(exp_pc));
			compare_word("inst_o.err", {31'b0, pkt.err}, {31'b0, err_for(exp_pc)});
		end
	end
endtask

task automatic drive_redirect(input logic [31:0] target);
	@(posedge clk_i);
	redirect_i.valid <= 1'b1;
	redirect_i.target <= target;
	@(posedge clk_i);
	redirect_i.valid <= 1'b0;
	@(negedge clk_i);
endtask

task automatic pulse_mret();
	@(posedge clk_i);
	mret_i <= 1'b1;
	@(posedge clk_i);
	mret_i <= 1'b0;
	@(negedge clk_i);
endtask

task automatic write_csr(input logic [11:0] addr, input logic [31:0] data);
	@(posedge clk_i);
	csr_wr_i.valid <= 1'b1;
	csr_wr_i.addr <= addr;
	csr_wr_i.data <= data;
	@(posedge clk_i);
	csr_wr_i.valid <= 1'b0;
endtask

// Combinational read port sampled half a cycle later
task automatic expect_csr(input logic [11:0] addr, input logic [31:0] exp, input string name);
	@(posedge clk_i);
	csr_rd_addr_i <= addr;
	@(negedge clk_i);
	compare_word(name, csr_rd_data_o, exp);
endtask

task automatic set_irq_lines(input logic [fetch_pkg::NUM_IRQ-1:0] lines);
	@(posedge clk_i);
	irq_lines_i <= lines;
	@(negedge clk_i);
endtask

task automatic reset_outputs_idle();
	compare_word("arvalid_o", {31'b0, arvalid_o}, 32'd0);
	compare_word("inst_valid_o", {31'b0, inst_valid_o}, 32'd0);
	compare_word("irq_take", {31'b0, DUT.u_pc_gen.irq_take_o}, 32'd0);
	compare_word("in_isr", {31'b0, DUT.u_pc_gen.in_isr_o}, 32'd0);
	compare_word("pc", DUT.u_pc_gen.pc_o, fetch_pkg::RESET_PC);
endtask

task automatic sequential_fetch();
	$display("Test 1: sequential fetch from the reset vector");
	verify_stream(fetch_pkg::RESET_PC, 0, 8);
endtask

// Stale packets would break the stream that starts at the target
task automatic redirect_flow();
	$display("Test 2: redirect");
	drive_redirect(32'h0000_0300);
	verify_stream(32'h0000_0300, 0, 6);
endtask

task automatic back_pressure();
	$display("Test 3: back-pressure");
	drive_redirect(32'h0000_0400);
	bp_en = 1'b1;
	verify_stream(32'h0000_0400, 0, 10);
	bp_en = 1'b0;
endtask

task automatic irq_entry();
	bit ok;
	int k;
	logic [31:0] vec;
	$display("Test 4: interrupt entry");
	vec = MTVEC_BASE + 32'd20;
	drive_redirect(32'h0000_0200);
	wait_for_packets(3, ok);
	write_csr(fetch_pkg::CSR_MTVEC, MTVEC_BASE);
	write_csr(fetch_pkg::CSR_MIE, 32'h0000_0020);
	expect_csr(fetch_pkg::CSR_MTVEC, MTVEC_BASE, "mtvec");
	// Line 6 pending too but masked
	set_irq_lines(8'b0110_0000);
	wait_for_pc(vec, k);
	if (k >= 0) begin
		checks++;
		assert (k > 0) else begin
			errors++;
			$display("Vector fetched with no instruction delivered before it");
		end
	end
	if (k > 0) begin
		saved_mepc = got_q[k - 1].pc + 32'd4;
		// A second entry would break the handler stream
		verify_stream(vec, k, 5);
		expect_csr(fetch_pkg::CSR_MEPC, saved_mepc, "mepc");
	end
endtask

task automatic irq_return_and_select();
	int k;
	logic [31:0] vec3;
	$display("Test 5: return from interrupt and lowest line selection");
	vec3 = MTVEC_BASE + 32'd12;
	set_irq_lines(8'h00);
	pulse_mret();
	verify_stream(saved_mepc, 0, 4);
	write_csr(fetch_pkg::CSR_MIE, 32'h0000_0028);
	set_irq_lines(8'b0010_1000);
	wait_for_pc(vec3, k);
	if (k > 0) begin
		// Handler for line 3 runs on and mepc holds the interrupted address
		verify_stream(vec3, k, 3);
		expect_csr(fetch_pkg::CSR_MEPC, got_q[k - 1].pc + 32'd4, "mepc");
	end
	set_irq_lines(8'h00);
	pulse_mret();
endtask

task automatic error_response();
	$display("Test 6: SLVERR response");
	drive_redirect(32'h0000_F100);
	verify_stream(32'h0000_F100, 0, 4);
endtask

`endif

/* tests/fetch_tb.sv */
`default_nettype none

module fetch_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 10;
	localparam int NUM_TESTS = 6;
	// 200 cycles per test plus margin
	localparam int WATCHDOG_CYCLES = NUM_TESTS * 200 + 100;
	localparam int WAIT_LIMIT = 150;
	localparam logic [31:0] SEED = 32'h80c8071b;
	localparam logic [31:0] MEM_XOR = 32'hA5A5_0000;
	localparam logic [31:0] ERR_BASE = 32'h0000_F000;
	localparam logic [31:0] MTVEC_BASE = 32'h0000_0800;

	logic clk_i = 1'b0;
	logic reset_i = 1'b1;
	fetch_pkg::redirect_t redirect_i = '0;
	logic mret_i = 1'b0;
	logic [fetch_pkg::NUM_IRQ-1:0] irq_lines_i = '0;
	fetch_pkg::csr_wr_t csr_wr_i = '0;
	logic [11:0] csr_rd_addr_i = '0;
	logic [31:0] csr_rd_data_o;
	fetch_pkg::axil_ar_t ar_o;
	logic arvalid_o;
	logic arready_i = 1'b0;
	fetch_pkg::axil_r_t r_i = '0;
	logic rvalid_i = 1'b0;
	logic rready_o;
	fetch_pkg::fetch_pkt_t inst_o;
	logic inst_valid_o;
	logic inst_ready_i = 1'b1;

	// Separate counters for the main process and the monitors
	int errors = 0;
	int checks = 0;
	int mon_errors = 0;
	int mon_checks = 0;

	// Packets taken by decode since the last flush
	fetch_pkg::fetch_pkt_t got_q[$];
	fetch_pkg::fetch_pkt_t held_pkt;
	logic stalled;

	// Memory model state
	logic mem_busy = 1'b0;
	int mem_delay = 0;
	logic [31:0] mem_addr = '0;

	// Decode back-pressure
	logic bp_en = 1'b0;
	int bp_span = 0;
	logic bp_level = 1'b1;

	logic [31:0] saved_mepc = '0;

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	fetch_top DUT (
		.clk_i(clk_i), .reset_i(reset_i),
		.redirect_i(redirect_i), .mret_i(mret_i), .irq_lines_i(irq_lines_i),
		.csr_wr_i(csr_wr_i), .csr_rd_addr_i(csr_rd_addr_i), .csr_rd_data_o(csr_rd_data_o),
		.ar_o(ar_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
		.r_i(r_i), .rvalid_i(rvalid_i), .rready_o(rready_o),
		.inst_o(inst_o), .inst_valid_o(inst_valid_o), .inst_ready_i(inst_ready_i)
	);

	// Memory word is the address XOR a fixed pattern
	function automatic logic [31:0] instr_for(input logic [31:0] addr);
		return addr ^ MEM_XOR;
	endfunction

	// Top of the map answers SLVERR
	function automatic logic err_for(input logic [31:0] addr);
		return addr >= ERR_BASE;
	endfunction

	// AXI4-Lite slave serving one read at a time with random arready and latency
	always @(posedge clk_i) begin
		if (reset_i) begin
			arready_i <= 1'b0;
			rvalid_i <= 1'b0;
			mem_busy <= 1'b0;
		end else if (!mem_busy) begin
			if (arvalid_o && arready_i) begin
				// Fetch reads are instruction accesses
				mon_checks++;
				assert (ar_o.arprot[2] == 1'b1) else begin
					mon_errors++;
					$display("ERROR ar_o.arprot[2]: got %h expected %h",
						ar_o.arprot[2], 1'b1);
				end
				mem_busy <= 1'b1;
				mem_addr <= ar_o.araddr;
				mem_delay <= int'($urandom % 4);
				arready_i <= 1'b0;
			end else begin
				arready_i <= 1'($urandom % 2);
			end
		end else if (rvalid_i) begin
			if (rready_o) begin
				rvalid_i <= 1'b0;
				mem_busy <= 1'b0;
			end
		end else if (mem_delay != 0) begin
			mem_delay <= mem_delay - 1;
		end else begin
			rvalid_i <= 1'b1;
			r_i.rdata <= instr_for(mem_addr);
			r_i.rresp <= err_for(mem_addr) ? 2'b10 : 2'b00;
		end
	end

	// Random spans of ready high and low
	always @(posedge clk_i) begin
		if (bp_en) begin
			if (bp_span == 0) begin
				bp_level = 1'($urandom % 2);
				bp_span = 1 + int'($urandom % 4);
			end
			bp_span--;
			inst_ready_i <= bp_level;
		end else begin
			inst_ready_i <= 1'b1;
		end
	end

	// Decode-side monitor where a redirect or mret starts a fresh stream
	always @(posedge clk_i) begin
		if (reset_i) begin
			got_q.delete();
			stalled = 1'b0;
		end else begin
			if (stalled) begin
				mon_checks++;
				assert (inst_valid_o && inst_o == held_pkt) else begin
					mon_errors++;
					$display("ERROR inst_o: changed while stalled, got %h expected %h",
						inst_o, held_pkt);
				end
			end
			stalled = inst_valid_o && !inst_ready_i && !(redirect_i.valid || mret_i);
			held_pkt = inst_o;
			if (redirect_i.valid || mret_i) begin
				got_q.delete();
			end else if (inst_valid_o && inst_ready_i) begin
				got_q.push_back(inst_o);
			end
		end
	end

	`include "fetch_tb_tasks.svh"

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		// Outputs checked inside the two reset cycles
		@(posedge clk_i);
		@(negedge clk_i);
		reset_outputs_idle();
		@(posedge clk_i);
		reset_i <= 1'b0;
		sequential_fetch();
		redirect_flow();
		back_pressure();
		irq_entry();
		irq_return_and_select();
		error_response();
		$display("Summary: %0d checks, %0d errors", checks + mon_checks, errors + mon_errors);
		if (errors + mon_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/fetch_top.sv */
`default_nettype none

module fetch_top (
	input wire clk_i,
	input wire reset_i,
	input wire fetch_pkg::redirect_t redirect_i,
	input wire mret_i,
	input wire [fetch_pkg::NUM_IRQ-1:0] irq_lines_i,
	// CSR access
	input wire fetch_pkg::csr_wr_t csr_wr_i,
	input wire [11:0] csr_rd_addr_i,
	output logic [fetch_pkg::XLEN-1:0] csr_rd_data_o,
	// AXI4-Lite read master
	output fetch_pkg::axil_ar_t ar_o,
	output logic arvalid_o,
	input wire arready_i,
	input wire fetch_pkg::axil_r_t r_i,
	input wire rvalid_i,
	output logic rready_o,
	// Decode side
	output fetch_pkg::fetch_pkt_t inst_o,
	output logic inst_valid_o,
	input wire inst_ready_i
);

	// PC handoff
	logic [fetch_pkg::XLEN-1:0] pc;
	logic pc_valid;
	logic pc_ready;
	logic flush;
	logic fetch_idle;
	// Interrupt path
	logic irq_req;
	logic [fetch_pkg::IRQ_ID_W-1:0] irq_id;
	logic irq_take;
	logic in_isr;
	// Trap registers
	logic [fetch_pkg::XLEN-1:0] mtvec;
	logic [fetch_pkg::XLEN-1:0] mepc;
	logic [fetch_pkg::NUM_IRQ-1:0] irq_enable;

	pc_gen u_pc_gen (
		.clk_i(clk_i), .reset_i(reset_i),
		.redirect_i(redirect_i), .mret_i(mret_i),
		.irq_req_i(irq_req), .irq_id_i(irq_id),
		.mtvec_i(mtvec), .mepc_i(mepc),
		.fetch_idle_i(fetch_idle), .pc_ready_i(pc_ready),
		.pc_o(pc), .pc_valid_o(pc_valid), .flush_o(flush),
		.irq_take_o(irq_take), .in_isr_o(in_isr)
	);

	irq_select u_irq_select (
		.irq_lines_i(irq_lines_i), .irq_enable_i(irq_enable), .in_isr_i(in_isr),
		.irq_req_o(irq_req), .irq_id_o(irq_id)
	);

	// mepc saves the pc that pc_gen was about to offer
	trap_csr u_trap_csr (
		.clk_i(clk_i), .reset_i(reset_i),
		.csr_wr_i(csr_wr_i), .csr_rd_addr_i(csr_rd_addr_i), .csr_rd_data_o(csr_rd_data_o),
		.irq_take_i(irq_take), .trap_pc_i(pc),
		.mtvec_o(mtvec), .mepc_o(mepc), .irq_enable_o(irq_enable)
	);

	fetch_axil u_fetch_axil (
		.clk_i(clk_i), .reset_i(reset_i),
		.pc_i(pc), .pc_valid_i(pc_valid), .pc_ready_o(pc_ready),
		.flush_i(flush), .idle_o(fetch_idle),
		.ar_o(ar_o), .arvalid_o(arvalid_o), .arready_i(arready_i),
		.r_i(r_i), .rvalid_i(rvalid_i), .rready_o(rready_o),
		.inst_o(inst_o), .inst_valid_o(inst_valid_o), .inst_ready_i(inst_ready_i)
	);

endmodule

`default_nettype wire

/* hdl/fetch_axil.sv */
`default_nettype none

module fetch_axil (
	input wire clk_i,
	input wire reset_i,
	// Address from pc_gen
	input wire [fetch_pkg::XLEN-1:0] pc_i,
	input wire pc_valid_i,
	output logic pc_ready_o,
	input wire flush_i,
	output logic idle_o,
	// AXI4-Lite read channels
	output fetch_pkg::axil_ar_t ar_o,
	output logic arvalid_o,
	input wire arready_i,
	input wire fetch_pkg::axil_r_t r_i,
	input wire rvalid_i,
	output logic rready_o,
	// Toward decode
	output fetch_pkg::fetch_pkt_t inst_o,
	output logic inst_valid_o,
	input wire inst_ready_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_WAIT
	} state_t;

	state_t state_q;
	logic [fetch_pkg::XLEN-1:0] req_pc_q;
	logic drop_q;
	fetch_pkg::fetch_pkt_t buf_q;
	logic buf_valid_q;
	logic buf_free;
	logic pc_fire;
	logic r_fire;
	logic buf_load;

	// Buffer can take a word if empty or draining now
	assign buf_free = ~buf_valid_q | inst_ready_i;

	// New address only between reads and with room for its data
	assign pc_ready_o = (state_q == ST_IDLE) & buf_free;
	assign pc_fire = pc_valid_i & pc_ready_o & ~flush_i;
	assign idle_o = (state_q == ST_IDLE);

	assign arvalid_o = (state_q == ST_ADDR);
	assign ar_o.araddr = req_pc_q;
	assign ar_o.arprot = fetch_pkg::AXI_PROT_INSN;

	// Stale responses are always taken, they never reach the buffer
	assign rready_o = (state_q == ST_WAIT) & (buf_free | drop_q | flush_i);
	assign r_fire = rvalid_i & rready_o;
	assign buf_load = r_fire & ~drop_q & ~flush_i;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= ST_IDLE;
			drop_q <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (pc_fire) begin
						state_q <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (arready_i) begin
						state_q <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (r_fire) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
			// Read in flight on flush, throw away its response
			if (r_fire) begin
				drop_q <= 1'b0;
			end else if (flush_i && state_q != ST_IDLE) begin
				drop_q <= 1'b1;
			end
		end
	end

	// Request address held for AR and tagged onto the data
	always_ff @(posedge clk_i) begin
		if (pc_fire) begin
			req_pc_q <= pc_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			buf_valid_q <= 1'b0;
		end else if (flush_i) begin
			buf_valid_q <= 1'b0;
		end else if (buf_load) begin
			buf_valid_q <= 1'b1;
		end else if (inst_ready_i) begin
			buf_valid_q <= 1'b0;
		end
	end

	// Payload only, err on anything but OKAY
	always_ff @(posedge clk_i) begin
		if (buf_load) begin
			buf_q.pc <= req_pc_q;
			buf_q.instr <= r_i.rdata;
			buf_q.err <= (r_i.rresp != fetch_pkg::AXI_RESP_OKAY);
		end
	end

	assign inst_o = buf_q;
	assign inst_valid_o = buf_valid_q;

	// AR payload held until the slave takes it
	a_ar_stable: assert property (
		@(posedge clk_i) disable iff (reset_i)
		arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o)
	);

	// Stalled packet is neither lost nor replaced
	a_buf_hold: assert property (
		@(posedge clk_i) disable iff (reset_i)
		inst_valid_o && !inst_ready_i && !flush_i |=> inst_valid_o && $stable(inst_o)
	);

endmodule

`default_nettype wire

/* hdl/trap_csr.sv */
`default_nettype none

module trap_csr (
	input wire clk_i,
	input wire reset_i,
	// Software write and combinational read
	input wire fetch_pkg::csr_wr_t csr_wr_i,
	input wire [11:0] csr_rd_addr_i,
	output logic [fetch_pkg::XLEN-1:0] csr_rd_data_o,
	// Interrupt entry saves the pc
	input wire irq_take_i,
	input wire [fetch_pkg::XLEN-1:0] trap_pc_i,
	output logic [fetch_pkg::XLEN-1:0] mtvec_o,
	output logic [fetch_pkg::XLEN-1:0] mepc_o,
	output logic [fetch_pkg::NUM_IRQ-1:0] irq_enable_o
);

	logic [fetch_pkg::XLEN-1:0] mtvec_q;
	logic [fetch_pkg::XLEN-1:0] mepc_q;
	logic [fetch_pkg::NUM_IRQ-1:0] mie_q;
	logic wr_mtvec;
	logic wr_mepc;
	logic wr_mie;

	assign wr_mtvec = csr_wr_i.valid && (csr_wr_i.addr == fetch_pkg::CSR_MTVEC);
	assign wr_mepc = csr_wr_i.valid && (csr_wr_i.addr == fetch_pkg::CSR_MEPC);
	assign wr_mie = csr_wr_i.valid && (csr_wr_i.addr == fetch_pkg::CSR_MIE);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			mtvec_q <= '0;
			mepc_q <= '0;
			mie_q <= '0;
		end else begin
			// Vector base kept word aligned
			if (wr_mtvec) begin
				mtvec_q <= {csr_wr_i.data[fetch_pkg::XLEN-1:2], 2'b00};
			end
			// Hardware capture beats a software write
			if (irq_take_i) begin
				mepc_q <= trap_pc_i;
			end else if (wr_mepc) begin
				mepc_q <= csr_wr_i.data;
			end
			if (wr_mie) begin
				mie_q <= csr_wr_i.data[fetch_pkg::NUM_IRQ-1:0];
			end
		end
	end

	// Unknown addresses read as zero
	always_comb begin
		case (csr_rd_addr_i)
			fetch_pkg::CSR_MTVEC: csr_rd_data_o = mtvec_q;
			fetch_pkg::CSR_MEPC: csr_rd_data_o = mepc_q;
			fetch_pkg::CSR_MIE:
				csr_rd_data_o = {{(fetch_pkg::XLEN - fetch_pkg::NUM_IRQ){1'b0}}, mie_q};
			default: csr_rd_data_o = '0;
		endcase
	end

	assign mtvec_o = mtvec_q;
	assign mepc_o = mepc_q;
	assign irq_enable_o = mie_q;

endmodule

`default_nettype wire

/* hdl/irq_select.sv */
`default_nettype none

module irq_select (
	input wire [fetch_pkg::NUM_IRQ-1:0] irq_lines_i,
	input wire [fetch_pkg::NUM_IRQ-1:0] irq_enable_i,
	input wire in_isr_i,
	output logic irq_req_o,
	output logic [fetch_pkg::IRQ_ID_W-1:0] irq_id_o
);

	logic [fetch_pkg::NUM_IRQ-1:0] pending;
	logic [fetch_pkg::NUM_IRQ-1:0] below_id;

	// Only enabled lines compete
	assign pending = irq_lines_i & irq_enable_i;

	// No new request inside a handler
	assign irq_req_o = (|pending) & ~in_isr_i;

	// Scan down so the lowest set line wins
	always_comb begin
		irq_id_o = '0;
		for (int i = fetch_pkg::NUM_IRQ - 1; i >= 0; i--) begin
			if (pending[i]) begin
				irq_id_o = i[fetch_pkg::IRQ_ID_W-1:0];
			end
		end
	end

	// Mask of all lines under the chosen id
	always_comb begin
		below_id = '0;
		for (int j = 0; j < fetch_pkg::NUM_IRQ; j++) begin
			if (j < int'(irq_id_o)) begin
				below_id[j] = 1'b1;
			end
		end
	end

	// Chosen line is enabled and pending, and nothing lower competes
	always_comb begin
		if (irq_req_o) begin
			a_id_enabled: assert (irq_enable_i[irq_id_o] && irq_lines_i[irq_id_o]);
			a_id_lowest: assert ((pending & below_id) == '0);
		end
	end

endmodule

`default_nettype wire

/* hdl/pc_gen.sv */
`default_nettype none

module pc_gen (
	input wire clk_i,
	input wire reset_i,
	// Execute stage redirect and return from interrupt
	input wire fetch_pkg::redirect_t redirect_i,
	input wire mret_i,
	// From the interrupt selector
	input wire irq_req_i,
	input wire [fetch_pkg::IRQ_ID_W-1:0] irq_id_i,
	// Trap registers
	input wire [fetch_pkg::XLEN-1:0] mtvec_i,
	input wire [fetch_pkg::XLEN-1:0] mepc_i,
	// Fetch unit status and handshake
	input wire fetch_idle_i,
	input wire pc_ready_i,
	output logic [fetch_pkg::XLEN-1:0] pc_o,
	output logic pc_valid_o,
	output logic flush_o,
	output logic irq_take_o,
	output logic in_isr_o
);

	logic [fetch_pkg::XLEN-1:0] pc_q;
	logic in_isr_q;
	logic [fetch_pkg::XLEN-1:0] vector_pc;
	logic pc_fire;

	// Vector entry is mtvec plus four times the line id
	assign vector_pc = mtvec_i +
		{{(fetch_pkg::XLEN - fetch_pkg::IRQ_ID_W - 2){1'b0}}, irq_id_i, 2'b00};

	// Redirect or mret kills whatever the fetch unit holds
	assign flush_o = redirect_i.valid | mret_i;

	// Entry only between reads so the current pc was never fetched
	// Selector withholds requests inside a handler
	assign irq_take_o = irq_req_i & fetch_idle_i & ~flush_o;

	// Current pc goes stale on any control change this cycle
	assign pc_valid_o = ~flush_o & ~irq_take_o;
	assign pc_fire = pc_valid_o & pc_ready_i;

	assign pc_o = pc_q;
	assign in_isr_o = in_isr_q;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			pc_q <= fetch_pkg::RESET_PC;
			in_isr_q <= 1'b0;
		end else if (redirect_i.valid) begin
			// Jump or taken branch has highest priority
			pc_q <= redirect_i.target;
		end else if (mret_i) begin
			// Resume at the saved address
			pc_q <= mepc_i;
			in_isr_q <= 1'b0;
		end else if (irq_take_o) begin
			pc_q <= vector_pc;
			in_isr_q <= 1'b1;
		end else if (pc_fire) begin
			// Sequential step on acceptance
			pc_q <= pc_q + 32'd4;
		end
	end

	// Every offered address is word aligned whatever its source
	a_pc_aligned: assert property (
		@(posedge clk_i) disable iff (reset_i)
		pc_valid_o |-> (pc_q[1:0] == 2'b00)
	);

	// Nothing is taken while a handler runs
	a_no_nested: assert property (
		@(posedge clk_i) disable iff (reset_i)
		in_isr_q |-> !irq_take_o
	);

endmodule

`default_nettype wire

/* hdl/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	// Data and address width
	localparam int XLEN = 32;

	// First fetch address after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0100;

	// Interrupt lines and id width
	localparam int NUM_IRQ = 8;
	localparam int IRQ_ID_W = 3;

	// Machine CSR addresses
	localparam logic [11:0] CSR_MTVEC = 12'h305;
	localparam logic [11:0] CSR_MEPC = 12'h341;
	localparam logic [11:0] CSR_MIE = 12'h304;

	// AXI encodings, instruction access and OKAY response
	localparam logic [2:0] AXI_PROT_INSN = 3'b100;
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	// Jump or taken branch from execute
	typedef struct packed {
		logic valid;
		logic [XLEN-1:0] target;
	} redirect_t;

	// Software CSR write
	typedef struct packed {
		logic valid;
		logic [11:0] addr;
		logic [XLEN-1:0] data;
	} csr_wr_t;

	// Instruction handed to decode
	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr;
		logic err;
	} fetch_pkt_t;

	// AXI4-Lite read address and read data payloads
	typedef struct packed {
		logic [XLEN-1:0] araddr;
		logic [2:0] arprot;
	} axil_ar_t;

	typedef struct packed {
		logic [XLEN-1:0] rdata;
		logic [1:0] rresp;
	} axil_r_t;

endpackage

`default_nettype wire
